//--- logic/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath width of operands and result
`define ALU_WIDTH   32

// Low operand bits used as shift amount
`define ALU_SHAMT_W 5

// Request queue entries, also the credits held after reset
`define ALU_Q_DEPTH 4

// Sequence tag width, wraps on overflow
`define ALU_TAG_W   4

`endif

//--- logic/alu_pkg.sv
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // ALU opcodes
    // Bit 3 marks the add/sub group, which alone produces carry and overflow
    // Bit 0 turns the adder into a subtractor (SUB and SLT both need a - b)
    typedef enum logic [3:0] {
        ALU_SLTU = 4'b0000,
        ALU_SLT  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRA  = 4'b0101,
        ALU_SLL  = 4'b0110,
        ALU_SRL  = 4'b0111,
        ALU_ADD  = 4'b1000,
        ALU_SUB  = 4'b1001
    } alu_op_e;

    // Status flags of one ALU operation
    typedef struct packed {
        logic neg;
        logic zero;
        logic carry;
        logic ovf;
    } alu_flags_t;

    // Decoded request, decoder to queue to execute stage
    typedef struct packed {
        alu_op_e                op;
        logic [`ALU_WIDTH-1:0]  a;
        logic [`ALU_WIDTH-1:0]  b;
        logic [`ALU_TAG_W-1:0]  tag;
    } alu_req_t;

    // Registered result leaving the execute stage
    typedef struct packed {
        logic [`ALU_WIDTH-1:0]  result;
        alu_flags_t             flags;
        logic [`ALU_TAG_W-1:0]  tag;
    } alu_rsp_t;

endpackage

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu #(
    parameter int WIDTH = `ALU_WIDTH
) (
    // Operation select
    input  alu_pkg::alu_op_e    alu_op_i,

    // Operands
    input  logic [WIDTH-1:0]    a_i,
    input  logic [WIDTH-1:0]    b_i,

    // Result and status
    output logic [WIDTH-1:0]    result_o,
    output alu_pkg::alu_flags_t flags_o
);

    import alu_pkg::*;

    localparam int SHAMT_W = $clog2(WIDTH);

    // Shared adder, subtracts when opcode bit 0 is set
    logic [WIDTH-1:0] b_eff;
    logic [WIDTH:0]   sum_ext;
    logic [WIDTH-1:0] sum;
    logic             carry_out;
    logic             v_add;
    logic             lt_signed;
    logic             lt_unsigned;
    logic [SHAMT_W-1:0] shamt;

    // Two's complement subtract as a + ~b + 1
    assign b_eff     = alu_op_i[0] ? ~b_i : b_i;
    assign sum_ext   = {1'b0, a_i} + {1'b0, b_eff} + {{WIDTH{1'b0}}, alu_op_i[0]};
    assign sum       = sum_ext[WIDTH-1:0];
    // Carry out of a + ~b + 1 is set exactly when a >= b unsigned
    assign carry_out = sum_ext[WIDTH];

    // Signed overflow for add or subtract
    assign v_add = ~(alu_op_i[0] ^ a_i[WIDTH-1] ^ b_i[WIDTH-1])
                 & (a_i[WIDTH-1] ^ sum[WIDTH-1]);

    // Signed less-than is N xor V of the difference
    assign lt_signed   = sum[WIDTH-1] ^ v_add;
    assign lt_unsigned = (a_i < b_i);

    // Only the low bits count as shift amount
    assign shamt = b_i[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = sum;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_SLT:  result_o = {{(WIDTH-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(WIDTH-1){1'b0}}, lt_unsigned};
            // Undefined opcode
            default:  result_o = 'x;
        endcase
    end

    // Sign and zero come straight from the result
    assign flags_o.neg  = result_o[WIDTH-1];
    assign flags_o.zero = (result_o == '0);

    // Carry and overflow only for the add/sub group
    assign flags_o.carry = alu_op_i[3] ? carry_out : 1'b0;
    assign flags_o.ovf   = alu_op_i[3] ? v_add : 1'b0;

endmodule

`default_nettype wire

//--- logic/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module op_decoder (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // Issue port
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  logic [2:0]              funct3_i,
    input  logic                    funct7_5_i,
    input  logic                    imm_sel_i,
    input  logic [`ALU_WIDTH-1:0]   rs1_i,
    input  logic [`ALU_WIDTH-1:0]   rs2_i,
    input  logic [`ALU_WIDTH-1:0]   imm_i,

    // Credit link to the queue
    input  logic                    credit_return_i,
    output logic                    push_o,
    output alu_pkg::alu_req_t       push_req_o
);

    import alu_pkg::*;

    // Counter must hold the full depth
    localparam int CRED_W = $clog2(`ALU_Q_DEPTH + 1);

    logic [CRED_W-1:0]      credits_q;
    logic [`ALU_TAG_W-1:0]  tag_q;
    logic                   accept;

    alu_op_e                op;
    logic                   is_shift;
    logic [`ALU_WIDTH-1:0]  opnd_b;

    // Ready whenever a queue slot is guaranteed
    assign issue_ready_o = (credits_q != '0);
    assign accept        = issue_valid_i & issue_ready_o;

    // Opcode from funct3, funct7 bit 5 picks SUB and SRA
    always_comb begin
        op       = ALU_ADD;
        is_shift = 1'b0;
        case (funct3_i)
            3'b000: op = (funct7_5_i && !imm_sel_i) ? ALU_SUB : ALU_ADD;
            3'b001: begin
                op       = ALU_SLL;
                is_shift = 1'b1;
            end
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: begin
                op       = funct7_5_i ? ALU_SRA : ALU_SRL;
                is_shift = 1'b1;
            end
            3'b110: op = ALU_OR;
            3'b111: op = ALU_AND;
        endcase
    end

    // Second operand, shifts keep only the shift amount bits
    always_comb begin
        opnd_b = imm_sel_i ? imm_i : rs2_i;
        if (is_shift) begin
            opnd_b = {{(`ALU_WIDTH-`ALU_SHAMT_W){1'b0}}, opnd_b[`ALU_SHAMT_W-1:0]};
        end
    end

    // Request goes out in the same cycle as the accepted issue
    assign push_o         = accept;
    assign push_req_o.op  = op;
    assign push_req_o.a   = rs1_i;
    assign push_req_o.b   = opnd_b;
    assign push_req_o.tag = tag_q;

    // Spend one credit per push, regain one per return
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credits_q <= CRED_W'(`ALU_Q_DEPTH);
        end else begin
            case ({accept, credit_return_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    // Wrapping sequence tag
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tag_q <= '0;
        end else if (accept) begin
            tag_q <= tag_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/op_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module op_queue (
    input  logic                clk,
    input  logic                rst_n_i,

    // Write side from the decoder
    input  logic                push_i,
    input  alu_pkg::alu_req_t   push_req_i,

    // Read side to the execute stage
    input  logic                pop_i,
    output logic                head_valid_o,
    output alu_pkg::alu_req_t   head_req_o,

    // One pulse per popped entry
    output logic                credit_return_o
);

    import alu_pkg::*;

    localparam int PTR_W = (`ALU_Q_DEPTH > 1) ? $clog2(`ALU_Q_DEPTH) : 1;
    localparam int CNT_W = $clog2(`ALU_Q_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`ALU_Q_DEPTH - 1);

    // Entry storage
    alu_req_t           mem [`ALU_Q_DEPTH];

    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               credit_q;

    // Head is visible as soon as one entry is stored
    assign head_valid_o    = (count_q != '0);
    assign head_req_o      = mem[rd_ptr_q];
    assign credit_return_o = credit_q;

    // No full check, the decoder never holds more credits than free slots
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_req_i;
        end
    end

    // Pointers wrap at the last index, depth need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // Occupancy and registered credit return
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            credit_q <= pop_i;
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst_n_i,

    // Queue head
    input  logic                head_valid_i,
    input  alu_pkg::alu_req_t   head_req_i,
    output logic                pop_o,

    // Result port
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output alu_pkg::alu_rsp_t   res_o
);

    import alu_pkg::*;

    logic [`ALU_WIDTH-1:0]  alu_result;
    alu_flags_t             alu_flags;

    logic                   res_valid_q;
    alu_rsp_t               res_q;
    logic                   slot_free;

    // ALU works on the queue head directly
    alu #(
        .WIDTH      (`ALU_WIDTH)
    ) u_alu (
        .alu_op_i   (head_req_i.op),
        .a_i        (head_req_i.a),
        .b_i        (head_req_i.b),
        .result_o   (alu_result),
        .flags_o    (alu_flags)
    );

    // Slot is free when empty or drained this cycle
    assign slot_free = ~res_valid_q | res_ready_i;
    assign pop_o     = head_valid_i & slot_free;

    // Valid bit follows pops and drains
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (pop_o) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    // Response payload only changes on a pop, so it holds while stalled
    always_ff @(posedge clk) begin
        if (pop_o) begin
            res_q.result <= alu_result;
            res_q.flags  <= alu_flags;
            res_q.tag    <= head_req_i.tag;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

`default_nettype wire

//--- logic/alu_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_cluster_top (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // Issue port
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  logic [2:0]              funct3_i,
    input  logic                    funct7_5_i,
    input  logic                    imm_sel_i,
    input  logic [`ALU_WIDTH-1:0]   rs1_i,
    input  logic [`ALU_WIDTH-1:0]   rs2_i,
    input  logic [`ALU_WIDTH-1:0]   imm_i,

    // Result port
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output alu_pkg::alu_rsp_t       res_o
);

    import alu_pkg::*;

    // Decoder to queue
    logic       push;
    alu_req_t   push_req;
    logic       credit_return;

    // Queue to execute stage
    logic       head_valid;
    alu_req_t   head_req;
    logic       pop;

    // Producer
    op_decoder u_op_decoder (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .funct3_i        (funct3_i),
        .funct7_5_i      (funct7_5_i),
        .imm_sel_i       (imm_sel_i),
        .rs1_i           (rs1_i),
        .rs2_i           (rs2_i),
        .imm_i           (imm_i),
        .credit_return_i (credit_return),
        .push_o          (push),
        .push_req_o      (push_req)
    );

    // Credit-managed buffer
    op_queue u_op_queue (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .push_i          (push),
        .push_req_i      (push_req),
        .pop_i           (pop),
        .head_valid_o    (head_valid),
        .head_req_o      (head_req),
        .credit_return_o (credit_return)
    );

    // Consumer with registered result
    exec_stage u_exec_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .head_valid_i    (head_valid),
        .head_req_i      (head_req),
        .pop_o           (pop),
        .res_valid_o     (res_valid_o),
        .res_ready_i     (res_ready_i),
        .res_o           (res_o)
    );

endmodule

`default_nettype wire

//--- dv/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Opcode from funct3, funct7 bit 5 only matters for register SUB and for SRA
function automatic alu_op_e decode_op(input logic [2:0] f3, input logic f7,
                                      input logic isel);
    case (f3)
        3'b000:  return (f7 && !isel) ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return f7 ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// Second operand, shifts keep only the shift amount
function automatic logic [`ALU_WIDTH-1:0] decode_b(input logic [2:0] f3, input logic isel,
                                                   input logic [`ALU_WIDTH-1:0] rs2,
                                                   input logic [`ALU_WIDTH-1:0] imm);
    logic [`ALU_WIDTH-1:0] b;
    b = isel ? imm : rs2;
    if (f3 == 3'b001 || f3 == 3'b101) begin
        b[`ALU_WIDTH-1:`ALU_SHAMT_W] = '0;
    end
    return b;
endfunction

// Expected result and flags, tag left at zero
function automatic alu_rsp_t model_response(input alu_op_e op,
                                            input logic [`ALU_WIDTH-1:0] a,
                                            input logic [`ALU_WIDTH-1:0] b);
    logic [`ALU_WIDTH:0] wide;
    alu_rsp_t            r;
    r = '0;
    case (op)
        ALU_ADD: begin
            wide          = {1'b0, a} + {1'b0, b};
            r.result      = wide[`ALU_WIDTH-1:0];
            r.flags.carry = wide[`ALU_WIDTH];
            // Same operand signs, different result sign
            r.flags.ovf   = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1])
                          && (r.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
        end
        ALU_SUB: begin
            r.result      = a - b;
            // Set when no borrow
            r.flags.carry = (a >= b);
            r.flags.ovf   = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1])
                          && (r.result[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
        end
        ALU_AND:  r.result = a & b;
        ALU_OR:   r.result = a | b;
        ALU_XOR:  r.result = a ^ b;
        ALU_SLL:  r.result = a << b[`ALU_SHAMT_W-1:0];
        ALU_SRL:  r.result = a >> b[`ALU_SHAMT_W-1:0];
        ALU_SRA:  r.result = $signed(a) >>> b[`ALU_SHAMT_W-1:0];
        ALU_SLT:  r.result = {{(`ALU_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
        ALU_SLTU: r.result = {{(`ALU_WIDTH-1){1'b0}}, a < b};
        default:  r.result = '0;
    endcase
    r.flags.neg  = r.result[`ALU_WIDTH-1];
    r.flags.zero = (r.result == '0);
    return r;
endfunction

`endif

//--- dv/alu_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_cluster_tb;

    import alu_pkg::*;

    `include "alu_ref_model.svh"

    localparam int W          = `ALU_WIDTH;
    localparam int WAIT_LIMIT = 200;
    localparam int RAND_COUNT = 300;

    logic           clk;
    logic           rst_n_i;
    logic           issue_valid_i;
    logic           issue_ready_o;
    logic [2:0]     funct3_i;
    logic           funct7_5_i;
    logic           imm_sel_i;
    logic [W-1:0]   rs1_i;
    logic [W-1:0]   rs2_i;
    logic [W-1:0]   imm_i;
    logic           res_valid_o;
    logic           res_ready_i;
    alu_rsp_t       res_o;

    // Scoreboard state, written by the monitor only
    alu_rsp_t               exp_q[$];
    logic [`ALU_TAG_W-1:0]  exp_tag = '0;
    int                     accepted_cnt = 0;
    int                     taken_cnt = 0;
    int                     last_issue_cyc = 0;
    int                     mon_errors = 0;
    int                     checks = 0;
    logic                   stall_seen = 1'b0;
    alu_rsp_t               held_rsp;

    // Main process state
    int                     drv_errors = 0;
    int                     tests = 0;
    int                     seed = 32'hb0c1;
    int                     cyc = 0;

    alu_cluster_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .funct3_i      (funct3_i),
        .funct7_5_i    (funct7_5_i),
        .imm_sel_i     (imm_sel_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i),
        .res_o         (res_o)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int total_errors();
        return mon_errors + drv_errors;
    endfunction

    // Monitor samples mid-cycle, a handshake seen here completes at the next edge
    always @(negedge clk) begin
        alu_rsp_t exp_rsp;
        if (issue_valid_i && issue_ready_o) begin
            exp_rsp = model_response(decode_op(funct3_i, funct7_5_i, imm_sel_i), rs1_i,
                                     decode_b(funct3_i, imm_sel_i, rs2_i, imm_i));
            exp_rsp.tag = exp_tag;
            exp_tag = exp_tag + 1'b1;
            exp_q.push_back(exp_rsp);
            accepted_cnt++;
            last_issue_cyc = cyc;
        end
        // Stalled response must not move
        if (stall_seen) begin
            if (!res_valid_o) begin
                $display("[ERROR] %0t: res_valid_o dropped while stalled", $time);
                mon_errors++;
            end else if (res_o !== held_rsp) begin
                $display("[ERROR] %0t: res_o changed while stalled, %h then %h",
                         $time, held_rsp, res_o);
                mon_errors++;
            end
        end
        if (res_valid_o && res_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Response with tag %0d arrived with no instruction outstanding",
                         res_o.tag);
                mon_errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                checks++;
                taken_cnt++;
                if (res_o.result !== exp_rsp.result) begin
                    $display("[ERROR] %0t: result %h, expected %h (tag %0d)",
                             $time, res_o.result, exp_rsp.result, exp_rsp.tag);
                    mon_errors++;
                end
                if (res_o.flags !== exp_rsp.flags) begin
                    $display("[ERROR] %0t: flags nzcv %b, expected %b (tag %0d)",
                             $time, res_o.flags, exp_rsp.flags, exp_rsp.tag);
                    mon_errors++;
                end
                if (res_o.tag !== exp_rsp.tag) begin
                    $display("[ERROR] %0t: tag %0d, expected %0d",
                             $time, res_o.tag, exp_rsp.tag);
                    mon_errors++;
                end
            end
        end
        stall_seen = res_valid_o && !res_ready_i;
        held_rsp   = res_o;
    end

    task automatic drive_instr(input logic [2:0] f3, input logic f7, input logic isel,
                               input logic [W-1:0] rs1, input logic [W-1:0] rs2,
                               input logic [W-1:0] imm);
        funct3_i   = f3;
        funct7_5_i = f7;
        imm_sel_i  = isel;
        rs1_i      = rs1;
        rs2_i      = rs2;
        imm_i      = imm;
    endtask

    task automatic drive_random_instr();
        logic [31:0]  r;
        logic [W-1:0] rs1;
        logic [W-1:0] rs2;
        logic [W-1:0] imm;
        r   = $random(seed);
        rs1 = $random(seed);
        rs2 = $random(seed);
        imm = $random(seed);
        // Now and then equal operands or a most negative value
        case (r[6:5])
            2'b00:   rs2 = rs1;
            2'b01:   rs1 = {1'b1, {(W-1){1'b0}}};
            default: ;
        endcase
        drive_instr(r[2:0], r[3], r[4], rs1, rs2, imm);
    endtask

    // Called and left 2 ns after a rising edge
    task automatic issue_one(input logic [2:0] f3, input logic f7, input logic isel,
                             input logic [W-1:0] rs1, input logic [W-1:0] rs2,
                             input logic [W-1:0] imm);
        int waited;
        waited = 0;
        drive_instr(f3, f7, isel, rs1, rs2, imm);
        issue_valid_i = 1'b1;
        @(negedge clk);
        while (!issue_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!issue_ready_o) begin
            $display("Issue port stayed busy for %0d cycles", WAIT_LIMIT);
            drv_errors++;
        end
        @(posedge clk);
        #2;
        issue_valid_i = 1'b0;
    endtask

    // Until every expected response is taken and the output is idle
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || res_valid_o) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0 || res_valid_o) begin
            $display("Results did not drain within %0d cycles, %0d still missing",
                     WAIT_LIMIT, exp_q.size());
            drv_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%s finished with %0d error(s)", name, total_errors() - errs_before);
    endtask

    initial begin
        int          errs;
        int          waited;
        int          acc0;
        int          taken0;
        logic [31:0] r;

        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        res_ready_i   = 1'b0;
        drive_instr(3'b000, 1'b0, 1'b0, '0, '0, '0);
        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // Reset state
        errs = total_errors();
        @(negedge clk);
        if (res_valid_o !== 1'b0 || issue_ready_o !== 1'b1) begin
            $display("[ERROR] %0t: after reset res_valid_o=%b issue_ready_o=%b",
                     $time, res_valid_o, issue_ready_o);
            drv_errors++;
        end
        @(posedge clk);
        #2;
        report_test("reset_state", errs);

        // Directed edge cases for every operation
        errs = total_errors();
        res_ready_i = 1'b1;
        issue_one(3'b000, 1'b0, 1'b0, 32'h7fff_ffff, 32'h0000_0001, 32'h0);
        issue_one(3'b000, 1'b0, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0);
        issue_one(3'b000, 1'b1, 1'b1, 32'h0000_000a, 32'h0, 32'hffff_fffb);
        issue_one(3'b000, 1'b1, 1'b0, 32'h8000_0000, 32'h0000_0001, 32'h0);
        issue_one(3'b000, 1'b1, 1'b0, 32'h0000_0001, 32'h0000_0002, 32'h0);
        issue_one(3'b000, 1'b1, 1'b0, 32'h0000_1234, 32'h0000_1234, 32'h0);
        issue_one(3'b001, 1'b0, 1'b0, 32'h0000_0001, 32'h0000_0021, 32'h0);
        issue_one(3'b001, 1'b0, 1'b1, 32'h8000_0001, 32'h0, 32'h0000_001f);
        issue_one(3'b101, 1'b0, 1'b0, 32'h8000_0000, 32'h0000_003f, 32'h0);
        issue_one(3'b101, 1'b1, 1'b1, 32'h8000_0000, 32'h0, 32'h0000_0024);
        issue_one(3'b010, 1'b0, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0);
        issue_one(3'b011, 1'b0, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0);
        issue_one(3'b100, 1'b0, 1'b0, 32'ha5a5_a5a5, 32'ha5a5_a5a5, 32'h0);
        issue_one(3'b110, 1'b0, 1'b0, 32'hf0f0_0000, 32'h0000_f0f0, 32'h0);
        issue_one(3'b111, 1'b0, 1'b1, 32'hffff_0000, 32'h0, 32'h8000_ffff);
        wait_drain();
        report_test("directed_ops", errs);

        // Single issue into an idle pipe
        errs = total_errors();
        issue_one(3'b000, 1'b0, 1'b0, 32'h0000_0003, 32'h0000_0004, 32'h0);
        waited = 0;
        @(negedge clk);
        while (!res_valid_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!res_valid_o) begin
            $display("No result appeared within %0d cycles of the issue", WAIT_LIMIT);
            drv_errors++;
        end else if (cyc - last_issue_cyc != 2) begin
            $display("[ERROR] %0t: latency %0d cycles, expected 2",
                     $time, cyc - last_issue_cyc);
            drv_errors++;
        end
        @(posedge clk);
        #2;
        wait_drain();
        report_test("unloaded_latency", errs);

        // Stall the output until credits run out
        errs = total_errors();
        res_ready_i   = 1'b0;
        acc0          = accepted_cnt;
        waited        = 0;
        issue_valid_i = 1'b1;
        drive_random_instr();
        @(negedge clk);
        while (issue_ready_o && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            drive_random_instr();
            waited++;
            @(negedge clk);
        end
        if (issue_ready_o) begin
            $display("Issue port never ran out of credits under back-pressure");
            drv_errors++;
        end
        // Ready must stay low while nothing drains
        repeat (3) begin
            @(negedge clk);
            if (issue_ready_o) begin
                $display("[ERROR] %0t: issue_ready_o rose with the output stalled", $time);
                drv_errors++;
            end
        end
        @(posedge clk);
        #2;
        issue_valid_i = 1'b0;
        if (accepted_cnt - acc0 != `ALU_Q_DEPTH + 1) begin
            $display("[ERROR] %0t: %0d issues accepted under stall, expected %0d",
                     $time, accepted_cnt - acc0, `ALU_Q_DEPTH + 1);
            drv_errors++;
        end
        res_ready_i = 1'b1;
        wait_drain();
        report_test("credit_exhaustion", errs);

        // Random issue and random back-pressure
        errs   = total_errors();
        acc0   = accepted_cnt;
        waited = 0;
        while (accepted_cnt - acc0 < RAND_COUNT && waited < RAND_COUNT * 20) begin
            r             = $random(seed);
            issue_valid_i = r[0];
            res_ready_i   = (r[2:1] != 2'b00);
            drive_random_instr();
            @(posedge clk);
            #2;
            waited++;
        end
        issue_valid_i = 1'b0;
        res_ready_i   = 1'b1;
        if (accepted_cnt - acc0 < RAND_COUNT) begin
            $display("Only %0d of %0d random instructions were accepted in time",
                     accepted_cnt - acc0, RAND_COUNT);
            drv_errors++;
        end
        wait_drain();
        report_test("random_traffic", errs);

        // Back-to-back issue with the output always ready
        errs          = total_errors();
        issue_valid_i = 1'b1;
        repeat (8) begin
            drive_random_instr();
            @(posedge clk);
            #2;
        end
        taken0 = taken_cnt;
        repeat (20) begin
            drive_random_instr();
            @(posedge clk);
            #2;
        end
        if (taken_cnt - taken0 != 20) begin
            $display("[ERROR] %0t: %0d results taken in 20 cycles, expected 20",
                     $time, taken_cnt - taken0);
            drv_errors++;
        end
        issue_valid_i = 1'b0;
        wait_drain();
        report_test("throughput", errs);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
+incdir+dv
logic/alu_pkg.sv
logic/alu.sv
logic/op_decoder.sv
logic/op_queue.sv
logic/exec_stage.sv
logic/alu_cluster_top.sv
dv/alu_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module alu_cluster_tb \
    -f src.f \
    -o alu_cluster_sim

./obj_dir/alu_cluster_sim > sim.log 2>&1
cat sim.log

# The testbench prints its verdict into the log
if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without reported failures"
